//--- Bender.yml
package:
  name: gb_host_bridge

sources:
  - source/gb_host_pkg.sv
  - source/clock_enable_gen.sv
  - source/sdram_request_mux.sv
  - source/lcd_to_vga.sv
  - source/gb_host_bridge.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_gb_host_bridge.sv

//--- bench/gb_host_ref.svh
`ifndef GB_HOST_REF_SVH
`define GB_HOST_REF_SVH

// Expected enables for clock period cyc after reset release, all low before it
function automatic gb_host_pkg::clk_en_t enables_at_cycle(input int cyc);
    gb_host_pkg::clk_en_t en;
    en = '0;
    if (cyc >= 0) begin
        en.cpu = (cyc % 16) == 15;
        // Half a CPU period away from the normal enable
        en.cpu_n = (cyc % 16) == 7;
        en.cpu2x = en.cpu || en.cpu_n;
        en.rtc = (cyc % 2048) == 2047;
    end
    return en;
endfunction

// Cartridge load: ROM code in the low six bits, or one of two whole codes
function automatic logic is_cart_load(input gb_host_pkg::ioctl_t io);
    return io.download && ((io.index[5:0] == 6'h01) || (io.index == 8'h00) ||
                           (io.index == 8'h80));
endfunction

function automatic gb_host_pkg::sdram_req_t build_sdram_req(
    input gb_host_pkg::ioctl_t io,
    input logic [22:0]        mbc_addr,
    input logic               cart_rd,
    input logic               cram_rd,
    input logic               dn_write
);
    gb_host_pkg::sdram_req_t req;
    req = '0;
    if (is_cart_load(io)) begin
        // Word write of the host data on both lanes
        req.addr = io.addr[24:1];
        req.din = io.dout;
        req.ds = 2'b11;
        req.we = dn_write;
    end else begin
        req.addr = {2'b00, mbc_addr[22:1]};
        // Odd byte address selects the upper lane
        req.ds = mbc_addr[0] ? 2'b10 : 2'b01;
        req.oe = cart_rd && !cram_rd;
    end
    return req;
endfunction

// Byte lane offset taken from the mapper address LSB
function automatic logic [7:0] pick_rom_byte(input logic [22:0] mbc_addr,
                                             input logic [15:0] sdram_do);
    return sdram_do[{mbc_addr[0], 3'b000} +: 8];
endfunction

// VGA value one cycle after the LCD input
function automatic gb_host_pkg::vga_t convert_lcd_pixel(input gb_host_pkg::lcd_t lcd);
    gb_host_pkg::vga_t v;
    logic [7:0] grey;
    case (lcd.shade)
        2'd0: grey = 8'hFF;
        2'd1: grey = 8'hAA;
        2'd2: grey = 8'h55;
        default: grey = 8'h00;
    endcase
    if (lcd.is_gbc) begin
        v.r = {lcd.rgb[14:10], lcd.rgb[14:12]};
        v.g = {lcd.rgb[9:5], lcd.rgb[9:7]};
        v.b = {lcd.rgb[4:0], lcd.rgb[4:2]};
    end else begin
        v.r = grey;
        v.g = grey;
        v.b = grey;
    end
    v.hs = lcd.mode != 2'd0;
    v.vs = lcd.mode != 2'd1;
    v.hb = !lcd.clkena;
    v.vb = lcd.mode == 2'd1;
    return v;
endfunction

// Black, syncs high, line blanked
function automatic gb_host_pkg::vga_t vga_reset_state();
    gb_host_pkg::vga_t v;
    v = '0;
    v.hs = 1'b1;
    v.vs = 1'b1;
    v.hb = 1'b1;
    return v;
endfunction

`endif

//--- bench/tb_gb_host_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module tb_gb_host_bridge;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 5;
    // Three RTC periods, plus the period before the first edge
    localparam int RTC_WINDOW = 3 * 2048 + 1;
    localparam int TOTAL_CYCLES = RST_CYCLES + RTC_WINDOW + 4;

    `include "gb_host_ref.svh"

    logic                                 clk_sys;
    logic                                 rst_n;
    gb_host_pkg::ioctl_t                  ioctl;
    logic [gb_host_pkg::MBC_ADDR_W-1:0]   mbc_addr;
    logic                                 cart_rd;
    logic                                 cram_rd;
    logic                                 dn_write;
    logic [gb_host_pkg::SDRAM_DATA_W-1:0] sdram_do;
    gb_host_pkg::lcd_t                    lcd;
    gb_host_pkg::clk_en_t                 clk_en;
    gb_host_pkg::sdram_req_t              sdram_req;
    logic                                 cart_download;
    logic [7:0]                           rom_byte;
    gb_host_pkg::vga_t                    vga;

    // Counters per test, tests 1 to 6
    int check_cnt [1:6] = '{default: 0};
    int err_cnt [1:6] = '{default: 0};
    // Clock period index since reset release
    int cyc = -2;
    gb_host_pkg::vga_t vga_exp;

    gb_host_bridge dut_i (
        .clk_sys         (clk_sys),
        .i_rst_n         (rst_n),
        .i_ioctl         (ioctl),
        .i_mbc_addr      (mbc_addr),
        .i_cart_rd       (cart_rd),
        .i_cram_rd       (cram_rd),
        .i_dn_write      (dn_write),
        .i_sdram_do      (sdram_do),
        .i_lcd           (lcd),
        .o_clk_en        (clk_en),
        .o_sdram_req     (sdram_req),
        .o_cart_download (cart_download),
        .o_rom_byte      (rom_byte),
        .o_vga           (vga)
    );

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    // ==============================
    // Watchdog
    // ==============================

    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("Timeout: run still busy after %0d clock cycles", 2 * TOTAL_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp, input int test_id);
        check_cnt[test_id]++;
        if (got !== exp) begin
            err_cnt[test_id]++;
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic report_test(input int test_id, input string title);
        // Let the last VGA sample reach the output
        repeat (2) @(negedge clk_sys);
        $display("test %0d %s: %0d checks, %0d errors", test_id, title,
                 check_cnt[test_id], err_cnt[test_id]);
    endtask

    // ==============================
    // Compare process
    // ==============================

    // Reads the values from before this edge, inputs settled since the falling edge
    always @(posedge clk_sys) begin : compare_outputs
        gb_host_pkg::clk_en_t    en_exp;
        gb_host_pkg::sdram_req_t req_exp;
        int                      mux_test;
        if (!rst_n) begin
            cyc = -2;
            vga_exp = vga_reset_state();
        end else begin
            cyc++;
            en_exp = enables_at_cycle(cyc);
            compare_value("o_clk_en.cpu", 64'(clk_en.cpu), 64'(en_exp.cpu), 1);
            compare_value("o_clk_en.cpu_n", 64'(clk_en.cpu_n), 64'(en_exp.cpu_n), 1);
            compare_value("o_clk_en.cpu2x", 64'(clk_en.cpu2x), 64'(en_exp.cpu2x), 1);
            compare_value("o_clk_en.rtc", 64'(clk_en.rtc), 64'(en_exp.rtc), 2);
            // Same cycle as the inputs
            req_exp = build_sdram_req(ioctl, mbc_addr, cart_rd, cram_rd, dn_write);
            mux_test = is_cart_load(ioctl) ? 3 : 4;
            compare_value("o_cart_download", 64'(cart_download), 64'(is_cart_load(ioctl)),
                          mux_test);
            compare_value("o_sdram_req.addr", 64'(sdram_req.addr), 64'(req_exp.addr), mux_test);
            compare_value("o_sdram_req.din", 64'(sdram_req.din), 64'(req_exp.din), mux_test);
            compare_value("o_sdram_req.ds", 64'(sdram_req.ds), 64'(req_exp.ds), mux_test);
            compare_value("o_sdram_req.oe", 64'(sdram_req.oe), 64'(req_exp.oe), mux_test);
            compare_value("o_sdram_req.we", 64'(sdram_req.we), 64'(req_exp.we), mux_test);
            compare_value("o_rom_byte", 64'(rom_byte), 64'(pick_rom_byte(mbc_addr, sdram_do)),
                          mux_test);
            // VGA holds the conversion of the LCD input seen one edge earlier
            compare_value("o_vga.rgb", 64'({vga.r, vga.g, vga.b}),
                          64'({vga_exp.r, vga_exp.g, vga_exp.b}), 5);
            compare_value("o_vga.hs", 64'(vga.hs), 64'(vga_exp.hs), 6);
            compare_value("o_vga.vs", 64'(vga.vs), 64'(vga_exp.vs), 6);
            compare_value("o_vga.hb", 64'(vga.hb), 64'(vga_exp.hb), 6);
            compare_value("o_vga.vb", 64'(vga.vb), 64'(vga_exp.vb), 6);
            vga_exp = convert_lcd_pixel(lcd);
        end
    end

    // ==============================
    // Stimulus
    // ==============================

    initial begin
        int total_checks;
        int total_errs;
        void'($urandom(32'h75d07b17));
        rst_n = 1'b0;
        ioctl = '0;
        mbc_addr = '0;
        cart_rd = 1'b0;
        cram_rd = 1'b0;
        dn_write = 1'b0;
        sdram_do = '0;
        lcd = '0;
        repeat (RST_CYCLES) @(negedge clk_sys);
        rst_n = 1'b1;

        // Downloads with known cartridge codes and random ones
        for (int i = 0; i < 200; i++) begin
            @(negedge clk_sys);
            ioctl.download = (i % 7) != 6;
            ioctl.wr = 1'($urandom);
            ioctl.addr = 25'($urandom);
            ioctl.dout = 16'($urandom);
            case (i % 5)
                0: ioctl.index = 8'h01;
                1: ioctl.index = 8'h41;
                2: ioctl.index = 8'h00;
                3: ioctl.index = 8'h80;
                default: ioctl.index = 8'($urandom);
            endcase
            dn_write = 1'($urandom);
            mbc_addr = 23'($urandom);
            cart_rd = 1'($urandom);
            sdram_do = 16'($urandom);
        end
        report_test(3, "download requests");

        // Mapper reads
        ioctl.download = 1'b0;
        for (int i = 0; i < 200; i++) begin
            @(negedge clk_sys);
            mbc_addr = 23'($urandom);
            cart_rd = 1'($urandom);
            cram_rd = 1'($urandom);
            dn_write = 1'($urandom);
            sdram_do = 16'($urandom);
        end
        report_test(4, "playback requests");

        // Random pixels of both console types
        for (int i = 0; i < 200; i++) begin
            @(negedge clk_sys);
            lcd = gb_host_pkg::lcd_t'($urandom);
        end
        report_test(5, "colour conversion");

        // Every mode with the pixel strobe toggling
        for (int i = 0; i < 64; i++) begin
            @(negedge clk_sys);
            lcd = gb_host_pkg::lcd_t'($urandom);
            lcd.mode = 2'((i / 8) % 4);
            lcd.clkena = i[0];
        end
        report_test(6, "sync and blank");

        // Enables are checked on every edge until three RTC periods have passed
        while (cyc < RTC_WINDOW) @(negedge clk_sys);
        report_test(1, "clock-enable cadence");
        report_test(2, "RTC enable");

        total_checks = 0;
        total_errs = 0;
        for (int t = 1; t <= 6; t++) begin
            total_checks += check_cnt[t];
            total_errs += err_cnt[t];
        end
        $display("checks %0d, errors %0d", total_checks, total_errs);
        if (total_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+bench
source/gb_host_pkg.sv
source/clock_enable_gen.sv
source/sdram_request_mux.sv
source/lcd_to_vga.sv
source/gb_host_bridge.sv
bench/tb_gb_host_bridge.sv

//--- source/clock_enable_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_enable_gen (
    input  wire                  clk_sys,
    input  wire                  i_rst_n,
    output gb_host_pkg::clk_en_t o_clk_en
);

    // ==============================
    // Dividers
    // ==============================

    logic [gb_host_pkg::CLK_DIV_W-1:0] clk_div;
    logic [gb_host_pkg::CLK_DIV_W-1:0] clk_div_next;
    logic [gb_host_pkg::RTC_DIV_W-1:0] rtc_div;
    logic [gb_host_pkg::RTC_DIV_W-1:0] rtc_div_next;

    // Enables decode the value the divider is about to take,
    // so each pulse lines up with its divider phase
    assign clk_div_next = clk_div + 1'b1;
    assign rtc_div_next = rtc_div + 1'b1;

    always_ff @(posedge clk_sys or negedge i_rst_n) begin
        if (!i_rst_n) begin
            clk_div <= '0;
            rtc_div <= '0;
        end else begin
            // Both dividers wrap freely
            clk_div <= clk_div_next;
            rtc_div <= rtc_div_next;
        end
    end

    // ==============================
    // Enable registers
    // ==============================

    always_ff @(posedge clk_sys or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_clk_en <= '0;
        end else begin
            // Normal speed CPU enable, 1 in 16
            o_clk_en.cpu <= (clk_div_next == gb_host_pkg::CE_CPU_PHASE);
            // Same rate, opposite half of the period
            o_clk_en.cpu_n <= (clk_div_next == gb_host_pkg::CE_CPU_N_PHASE);
            // Double speed fires on both phases, 1 in 8
            o_clk_en.cpu2x <= (clk_div_next == gb_host_pkg::CE_CPU_PHASE) ||
                              (clk_div_next == gb_host_pkg::CE_CPU_N_PHASE);
            // RTC tick near 32 kHz
            o_clk_en.rtc <= (rtc_div_next == '0);
        end
    end

    // ==============================
    // Checks
    // ==============================

    // The two CPU phases never overlap
    a_cpu_phases_apart: assert property (
        @(posedge clk_sys) disable iff (!i_rst_n)
        !(o_clk_en.cpu && o_clk_en.cpu_n)
    );

    // Every normal speed tick is also a double speed tick
    a_cpu_in_cpu2x: assert property (
        @(posedge clk_sys) disable iff (!i_rst_n)
        o_clk_en.cpu |-> o_clk_en.cpu2x
    );

endmodule

`default_nettype wire

//--- source/gb_host_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module gb_host_bridge (
    input  wire                                 clk_sys,
    input  wire                                 i_rst_n,

    // Host download port
    input  wire gb_host_pkg::ioctl_t            i_ioctl,

    // Mapper side
    input  wire [gb_host_pkg::MBC_ADDR_W-1:0]   i_mbc_addr,
    input  wire                                 i_cart_rd,
    input  wire                                 i_cram_rd,
    input  wire                                 i_dn_write,

    // SDRAM read data
    input  wire [gb_host_pkg::SDRAM_DATA_W-1:0] i_sdram_do,

    // LCD stream from the video unit
    input  wire gb_host_pkg::lcd_t              i_lcd,

    // Enables for core and cartridge
    output wire gb_host_pkg::clk_en_t           o_clk_en,

    // SDRAM request and ROM byte
    output wire gb_host_pkg::sdram_req_t        o_sdram_req,
    output wire                                 o_cart_download,
    output wire [7:0]                           o_rom_byte,

    // Video out
    output wire gb_host_pkg::vga_t              o_vga
);

    // ==============================
    // Clock enables
    // ==============================

    clock_enable_gen clk_en_i (
        .clk_sys  (clk_sys),
        .i_rst_n  (i_rst_n),
        .o_clk_en (o_clk_en)
    );

    // ==============================
    // SDRAM request path
    // ==============================

    // Combinational, same cycle as its inputs
    sdram_request_mux sdram_mux_i (
        .clk_sys         (clk_sys),
        .i_rst_n         (i_rst_n),
        .i_ioctl         (i_ioctl),
        .i_mbc_addr      (i_mbc_addr),
        .i_cart_rd       (i_cart_rd),
        .i_cram_rd       (i_cram_rd),
        .i_dn_write      (i_dn_write),
        .i_sdram_do      (i_sdram_do),
        .o_sdram_req     (o_sdram_req),
        .o_cart_download (o_cart_download),
        .o_rom_byte      (o_rom_byte)
    );

    // ==============================
    // Video path
    // ==============================

    // One register stage from LCD to VGA
    lcd_to_vga lcd_vga_i (
        .clk_sys (clk_sys),
        .i_rst_n (i_rst_n),
        .i_lcd   (i_lcd),
        .o_vga   (o_vga)
    );

endmodule

`default_nettype wire

//--- source/gb_host_pkg.sv
`default_nettype none

package gb_host_pkg;

    // ==============================
    // Widths and sizes
    // ==============================

    // CPU enable divider, one pulse per 16 system clocks
    localparam int CLK_DIV_W = 4;
    // RTC divider, one pulse per 2048 system clocks
    localparam int RTC_DIV_W = 11;

    // Download byte address from the host
    localparam int IOCTL_ADDR_W = 25;
    // Mapper byte address into cartridge ROM
    localparam int MBC_ADDR_W = 23;
    // SDRAM is word addressed, so one bit less than a byte address
    localparam int SDRAM_ADDR_W = 24;
    localparam int SDRAM_DATA_W = 16;
    localparam int LOAD_INDEX_W = 8;

    // ==============================
    // Constants
    // ==============================

    // Divider phases for the two CPU enables, half a period apart
    localparam logic [CLK_DIV_W-1:0] CE_CPU_PHASE = 4'd0;
    localparam logic [CLK_DIV_W-1:0] CE_CPU_N_PHASE = 4'd8;

    // Cartridge ROM code in the low six bits of the download index
    localparam logic [5:0] CART_INDEX_ROM = 6'h01;
    // Full index codes that also count as a cartridge load
    localparam logic [LOAD_INDEX_W-1:0] CART_INDEX_BOOT = 8'h00;
    localparam logic [LOAD_INDEX_W-1:0] CART_INDEX_ALT = 8'h80;

    // Monochrome grey levels, shade 0 is white and shade 3 is black
    // Element 0 sits in the lowest byte
    localparam logic [3:0][7:0] DMG_SHADE = {8'h00, 8'h55, 8'hAA, 8'hFF};

    // LCD mode codes as reported by the video unit
    localparam logic [1:0] LCD_MODE_HBLANK = 2'd0;
    localparam logic [1:0] LCD_MODE_VBLANK = 2'd1;

    // ==============================
    // Struct types
    // ==============================

    // Clock enables for the console core and the cartridge RTC
    typedef struct packed {
        logic cpu;
        logic cpu_n;
        logic cpu2x;
        logic rtc;
    } clk_en_t;

    // Host download port
    typedef struct packed {
        logic                    download;
        logic                    wr;
        logic [IOCTL_ADDR_W-1:0] addr;
        logic [SDRAM_DATA_W-1:0] dout;
        logic [LOAD_INDEX_W-1:0] index;
    } ioctl_t;

    // Request towards the SDRAM controller
    typedef struct packed {
        logic [SDRAM_ADDR_W-1:0] addr;
        logic [SDRAM_DATA_W-1:0] din;
        // Byte strobes, bit 1 is the upper lane
        logic [1:0]              ds;
        logic                    oe;
        logic                    we;
    } sdram_req_t;

    // LCD stream from the video unit
    typedef struct packed {
        logic        clkena;
        logic [1:0]  mode;
        // RGB555 with red in the top five bits
        logic [14:0] rgb;
        logic [1:0]  shade;
        logic        is_gbc;
    } lcd_t;

    // VGA style output, sync and blank are levels
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic       hs;
        logic       vs;
        logic       hb;
        logic       vb;
    } vga_t;

endpackage

`default_nettype wire

//--- source/lcd_to_vga.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_to_vga (
    input  wire                   clk_sys,
    input  wire                   i_rst_n,
    input  wire gb_host_pkg::lcd_t i_lcd,
    output gb_host_pkg::vga_t     o_vga
);

    // ==============================
    // Colour path
    // ==============================

    logic [7:0]        grey;
    logic [4:0]        red5;
    logic [4:0]        green5;
    logic [4:0]        blue5;
    gb_host_pkg::vga_t vga_d;

    // Shade 0 is the lightest grey
    assign grey = gb_host_pkg::DMG_SHADE[i_lcd.shade];

    // Split RGB555, red on top
    assign red5 = i_lcd.rgb[14:10];
    assign green5 = i_lcd.rgb[9:5];
    assign blue5 = i_lcd.rgb[4:0];

    always_comb begin
        if (i_lcd.is_gbc) begin
            // Repeat the top bits so full scale maps to FF
            vga_d.r = {red5, red5[4:2]};
            vga_d.g = {green5, green5[4:2]};
            vga_d.b = {blue5, blue5[4:2]};
        end else begin
            // Monochrome game, same grey on all channels
            vga_d.r = grey;
            vga_d.g = grey;
            vga_d.b = grey;
        end

        // ==============================
        // Sync and blank levels
        // ==============================

        // Syncs are low for the whole blank period
        vga_d.hs = (i_lcd.mode != gb_host_pkg::LCD_MODE_HBLANK);
        vga_d.vs = (i_lcd.mode != gb_host_pkg::LCD_MODE_VBLANK);
        // Active video only while the LCD pixel strobe is up
        vga_d.hb = !i_lcd.clkena;
        vga_d.vb = (i_lcd.mode == gb_host_pkg::LCD_MODE_VBLANK);
    end

    // ==============================
    // Output register
    // ==============================

    always_ff @(posedge clk_sys or negedge i_rst_n) begin
        if (!i_rst_n) begin
            // Black screen, syncs idle high, blanked line
            o_vga.r <= '0;
            o_vga.g <= '0;
            o_vga.b <= '0;
            o_vga.hs <= 1'b1;
            o_vga.vs <= 1'b1;
            o_vga.hb <= 1'b1;
            o_vga.vb <= 1'b0;
        end else begin
            o_vga <= vga_d;
        end
    end

    // ==============================
    // Checks
    // ==============================

    // Vertical blank always comes with vertical sync active
    a_vb_has_vs: assert property (
        @(posedge clk_sys) disable iff (!i_rst_n)
        o_vga.vb |-> !o_vga.vs
    );

endmodule

`default_nettype wire

//--- source/sdram_request_mux.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_request_mux (
    input  wire                                     clk_sys,
    input  wire                                     i_rst_n,
    input  wire gb_host_pkg::ioctl_t                i_ioctl,
    input  wire [gb_host_pkg::MBC_ADDR_W-1:0]       i_mbc_addr,
    input  wire                                     i_cart_rd,
    input  wire                                     i_cram_rd,
    input  wire                                     i_dn_write,
    input  wire [gb_host_pkg::SDRAM_DATA_W-1:0]     i_sdram_do,
    output gb_host_pkg::sdram_req_t                 o_sdram_req,
    output logic                                    o_cart_download,
    output logic [7:0]                              o_rom_byte
);

    // Zero bits that pad the mapper word address up to the SDRAM width
    localparam int PAD_W = gb_host_pkg::SDRAM_ADDR_W - gb_host_pkg::MBC_ADDR_W + 1;

    // ==============================
    // Download decode
    // ==============================

    logic index_rom;
    logic index_full;

    // ROM code may carry extra flags in the top two bits
    assign index_rom = (i_ioctl.index[5:0] == gb_host_pkg::CART_INDEX_ROM);
    // Two whole codes also load the cartridge
    assign index_full = (i_ioctl.index == gb_host_pkg::CART_INDEX_BOOT) ||
                        (i_ioctl.index == gb_host_pkg::CART_INDEX_ALT);

    assign o_cart_download = i_ioctl.download && (index_rom || index_full);

    // ==============================
    // Request steering
    // ==============================

    always_comb begin
        if (o_cart_download) begin
            // Host writes whole words, byte address halved
            o_sdram_req.addr = i_ioctl.addr[gb_host_pkg::IOCTL_ADDR_W-1:1];
            o_sdram_req.din = i_ioctl.dout;
            o_sdram_req.ds = 2'b11;
            o_sdram_req.oe = 1'b0;
            o_sdram_req.we = i_dn_write;
        end else begin
            // Mapper reads single bytes from the word address
            o_sdram_req.addr = {{PAD_W{1'b0}}, i_mbc_addr[gb_host_pkg::MBC_ADDR_W-1:1]};
            o_sdram_req.din = '0;
            // Odd byte lives in the upper lane
            o_sdram_req.ds = {i_mbc_addr[0], ~i_mbc_addr[0]};
            // Cart RAM reads are served elsewhere
            o_sdram_req.oe = i_cart_rd && !i_cram_rd;
            o_sdram_req.we = 1'b0;
        end
    end

    // ==============================
    // ROM byte select
    // ==============================

    // Same lane rule as the byte strobes
    assign o_rom_byte = i_mbc_addr[0] ? i_sdram_do[15:8] : i_sdram_do[7:0];

    // ==============================
    // Checks
    // ==============================

    // Read and write requests are mutually exclusive
    a_no_rd_wr_overlap: assert property (
        @(posedge clk_sys) disable iff (!i_rst_n)
        !(o_sdram_req.oe && o_sdram_req.we)
    );

endmodule

`default_nettype wire
